// File: sources.f
logic/cache_pkg.sv
logic/cache_sram.sv
logic/cache_ctrl.sv
logic/cache_dpath.sv
logic/cache_top.sv
verification/tb_mem_model.sv
verification/tb_cache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the cache testbench with Verilator and run it
# exit status is nonzero when the build fails or the testbench stops on an error

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_cache

verilator --binary --assert -Wno-fatal \
  --top-module tb_cache \
  -f sources.f \
  --Mdir "$build_dir" -o "$sim_bin"
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit "$build_status"
fi

"./$build_dir/$sim_bin"
run_status=$?
if [ "$run_status" -ne 0 ]; then
  echo "simulation failed with status $run_status"
  exit "$run_status"
fi

echo "simulation passed"
exit 0

// File: verification/tb_cache.sv
module tb_cache;
  timeunit 1ns;
  timeprecision 100ps;
  import cache_pkg::*;

  localparam int    NUM_LINES      = 32;
  localparam int    WORDS_PER_LINE = 16;
  localparam int    MEM_WORDS      = 4096;  // eight tags over the whole cache
  localparam int    MEM_AW         = $clog2(MEM_WORDS);
  localparam word_t FILL           = 32'h5ca1_ab1e;
  localparam int    SEED           = 84232;
  localparam int    NUM_PHASES     = 5;
  localparam int    PHASE_CYCLES   = 2000;
  localparam addr_t WAY_STRIDE     = NUM_LINES * WORDS_PER_LINE;  // same index, next tag

  logic  clk;
  logic  reset;
  logic  req_val;
  logic  req_rdy;
  logic  req_write;
  addr_t req_addr;
  word_t req_data;
  logic  resp_val;
  logic  resp_rdy;
  word_t resp_data;
  logic  mem_req_val;
  logic  mem_req_rdy;
  logic  mem_req_write;
  addr_t mem_req_addr;
  word_t mem_req_data;
  logic  mem_resp_val;
  logic  mem_resp_rdy;
  word_t mem_resp_data;
  logic  flush;
  logic  flush_done;

  word_t ref_mem [MEM_WORDS];  // expected memory image
  addr_t exp_addr;             // address of the request in flight
  logic  pending;              // accepted, response not yet taken
  int    seed = SEED;
  int    rdy_seed = SEED + 1;

  cache_top #(
    .NUM_LINES      (NUM_LINES),
    .WORDS_PER_LINE (WORDS_PER_LINE)
  ) u_cache_top (.*);

  tb_mem_model #(
    .MEM_WORDS (MEM_WORDS),
    .FILL      (FILL),
    .SEED      (SEED)
  ) u_mem_model (
    .clk       (clk),
    .reset     (reset),
    .req_val   (mem_req_val),
    .req_rdy   (mem_req_rdy),
    .req_write (mem_req_write),
    .req_addr  (mem_req_addr),
    .req_data  (mem_req_data),
    .resp_val  (mem_resp_val),
    .resp_rdy  (mem_resp_rdy),
    .resp_data (mem_resp_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    resp_rdy <= 1'b0;
    forever begin
      @(posedge clk);
      resp_rdy <= !reset && (($random(rdy_seed) & 3) != 0);  // random back-pressure
    end
  end

  // ====================
  // reference model
  // ====================

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        ref_mem[i] = word_t'(i) ^ FILL;
      end
      pending <= 1'b0;
    end else if (req_val && req_rdy) begin
      if (req_write) begin
        ref_mem[req_addr[MEM_AW-1:0]] = req_data;
      end
      exp_addr <= req_addr;
      pending  <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      pending <= 1'b0;
    end
  end

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_fail(input string msg);
    stop_with_error($sformatf("CHECK FAILED at %0d ns: %s", $time, msg));
  endtask

  // ====================
  // checks
  // ====================

  a_resp_matches_ref: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> resp_data == ref_mem[exp_addr[MEM_AW-1:0]])
    else check_fail($sformatf("access to %h returned %h, expected %h",
                              exp_addr, resp_data, ref_mem[exp_addr[MEM_AW-1:0]]));

  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_data))
    else check_fail("response dropped or changed while stalled");

  a_busy_while_pending: assert property (@(posedge clk) disable iff (reset)
    pending |-> !req_rdy)
    else check_fail("req_rdy high with a response pending");

  a_flush_blocks_req: assert property (@(posedge clk) disable iff (reset)
    flush |-> !(req_val && req_rdy))
    else check_fail("request accepted while flush high");

  a_flush_done_hold: assert property (@(posedge clk) disable iff (reset)
    flush && flush_done |=> flush_done)
    else check_fail("flush_done fell before flush");

  task automatic check_backing(input addr_t addr);
    assert (u_mem_model.mem[addr[MEM_AW-1:0]] == ref_mem[addr[MEM_AW-1:0]])
      else check_fail($sformatf("memory word %h is %h, expected %h", addr,
                                u_mem_model.mem[addr[MEM_AW-1:0]], ref_mem[addr[MEM_AW-1:0]]));
  endtask

  task automatic wait_accept();
    do @(posedge clk); while (!(req_val && req_rdy));
    req_val <= 1'b0;
  endtask

  task automatic wait_response();
    do @(posedge clk); while (!(resp_val && resp_rdy));
  endtask

  task automatic cpu_access(input logic is_write, input addr_t addr, input word_t data);
    @(posedge clk);
    req_val   <= 1'b1;
    req_write <= is_write;
    req_addr  <= addr;
    req_data  <= data;
    wait_accept();
    wait_response();
  endtask

  // read offered together with the flush, must wait until flush drops
  task automatic flush_with_waiting_read(input addr_t addr);
    @(posedge clk);
    flush     <= 1'b1;
    req_val   <= 1'b1;
    req_write <= 1'b0;
    req_addr  <= addr;
    do @(posedge clk); while (!flush_done);
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_backing(addr_t'(i));  // whole image written back
    end
    flush <= 1'b0;
    wait_accept();
    wait_response();
  endtask

  initial begin
    addr_t a;
    word_t d;
    reset     <= 1'b1;
    req_val   <= 1'b0;
    req_write <= 1'b0;
    req_addr  <= '0;
    req_data  <= '0;
    flush     <= 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    assert (!resp_val && !mem_req_val && !mem_resp_rdy && !flush_done && req_rdy)
      else check_fail("outputs not at their idle values after reset");

    // untouched words, miss then hit
    cpu_access(1'b0, 32'h0000_0040, '0);
    cpu_access(1'b0, 32'h0000_0047, '0);  // same line
    cpu_access(1'b0, 32'h0000_0040, '0);

    // write then read back, hit and miss
    cpu_access(1'b1, 32'h0000_0045, 32'h1234_5678);
    cpu_access(1'b0, 32'h0000_0045, '0);
    cpu_access(1'b1, 32'h0000_0a13, 32'hdead_beef);  // refill then merge
    cpu_access(1'b0, 32'h0000_0a13, '0);
    cpu_access(1'b0, 32'h0000_0a1c, '0);             // neighbour from the refill

    // conflict on one index
    a = 32'h0000_0123;
    cpu_access(1'b1, a, 32'h0bad_cafe);
    cpu_access(1'b0, a + WAY_STRIDE, '0);  // evicts the dirty line
    check_backing(a);
    cpu_access(1'b0, a, '0);

    // random writes, then flush
    repeat (12) begin
      a = addr_t'($random(seed)) & addr_t'(MEM_WORDS - 1);
      d = word_t'($random(seed));
      cpu_access(1'b1, a, d);
    end
    a = addr_t'($random(seed)) & addr_t'(MEM_WORDS - 1);
    flush_with_waiting_read(a);

    // random mix under back-pressure
    repeat (16) begin
      a = addr_t'($random(seed)) & addr_t'(MEM_WORDS - 1);
      d = word_t'($random(seed));
      cpu_access(d[0], a, d);
    end

    $display("Done: no errors");
    $finish;
  end

  initial begin
    repeat (NUM_PHASES * PHASE_CYCLES) @(posedge clk);
    stop_with_error($sformatf("watchdog expired after %0d cycles, the run hung",
                              NUM_PHASES * PHASE_CYCLES));
  end

endmodule

// File: verification/tb_mem_model.sv
module tb_mem_model #(
  parameter int               MEM_WORDS = 4096,
  parameter cache_pkg::word_t FILL      = 32'h0,
  parameter int               SEED      = 1,
  localparam int AW = $clog2(MEM_WORDS)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             req_val,
  output logic             req_rdy,
  input  logic             req_write,
  input  cache_pkg::addr_t req_addr,
  input  cache_pkg::word_t req_data,
  output logic             resp_val,
  input  logic             resp_rdy,
  output cache_pkg::word_t resp_data
);
  timeunit 1ns;
  timeprecision 100ps;
  import cache_pkg::*;

  word_t mem [MEM_WORDS];  // backing store
  word_t read_q [$];       // read data waiting to go back, oldest first
  int    seed = SEED;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = word_t'(i) ^ FILL;  // every word tells its own address
    end
    req_rdy   <= 1'b0;
    resp_val  <= 1'b0;
    resp_data <= '0;
    forever begin
      @(posedge clk);
      if (reset) begin
        req_rdy  <= 1'b0;
        resp_val <= 1'b0;
        read_q.delete();
      end else begin
        if (resp_val && resp_rdy) begin
          void'(read_q.pop_front());  // oldest read delivered
        end
        if (req_val && req_rdy) begin
          if (req_write) begin
            mem[req_addr[AW-1:0]] = req_data;
          end else begin
            read_q.push_back(mem[req_addr[AW-1:0]]);  // data frozen at acceptance
          end
        end
        if (resp_val && !resp_rdy) begin
          resp_val <= 1'b1;  // hold word until taken
        end else if (read_q.size() > 0 && ($random(seed) & 3) != 0) begin
          resp_val  <= 1'b1;
          resp_data <= read_q[0];  // in request order
        end else begin
          resp_val <= 1'b0;  // idle or a random delay
        end
        req_rdy <= ($random(seed) & 3) != 0;  // stall about one cycle in four
      end
    end
  end

endmodule

// File: logic/cache_top.sv
module cache_top #(
  parameter int NUM_LINES      = 32,
  parameter int WORDS_PER_LINE = 16,
  localparam int IDX_W = $clog2(NUM_LINES),
  localparam int CNT_W = $clog2(WORDS_PER_LINE) + 1
) (
  input  logic             clk,
  input  logic             reset,
  // processor request and response
  input  logic             req_val,
  output logic             req_rdy,
  input  logic             req_write,
  input  cache_pkg::addr_t req_addr,
  input  cache_pkg::word_t req_data,
  output logic             resp_val,
  input  logic             resp_rdy,
  output cache_pkg::word_t resp_data,
  // memory request and response
  output logic             mem_req_val,
  input  logic             mem_req_rdy,
  output logic             mem_req_write,
  output cache_pkg::addr_t mem_req_addr,
  output cache_pkg::word_t mem_req_data,
  input  logic             mem_resp_val,
  output logic             mem_resp_rdy,
  input  cache_pkg::word_t mem_resp_data,
  // flush
  input  logic             flush,
  output logic             flush_done
);

  // controller to datapath
  logic             req_capture;
  logic             tag_rd_en;
  logic             tag_wr_en;
  logic             data_rd_en;
  logic             data_wr_en;
  logic             fill_sel;
  logic             evict_sel;
  logic [CNT_W-1:0] req_word_cnt;
  logic [CNT_W-1:0] resp_word_cnt;
  logic [IDX_W-1:0] flush_index;
  // datapath to controller
  logic             tag_match;
  logic [IDX_W-1:0] cur_index;
  logic             cur_write;

  cache_ctrl #(
    .NUM_LINES      (NUM_LINES),
    .WORDS_PER_LINE (WORDS_PER_LINE)
  ) u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .req_val       (req_val),
    .req_rdy       (req_rdy),
    .resp_val      (resp_val),
    .resp_rdy      (resp_rdy),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_req_write (mem_req_write),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy),
    .flush         (flush),
    .flush_done    (flush_done),
    .req_capture   (req_capture),
    .tag_rd_en     (tag_rd_en),
    .tag_wr_en     (tag_wr_en),
    .data_rd_en    (data_rd_en),
    .data_wr_en    (data_wr_en),
    .fill_sel      (fill_sel),
    .evict_sel     (evict_sel),
    .req_word_cnt  (req_word_cnt),
    .resp_word_cnt (resp_word_cnt),
    .flush_index   (flush_index),
    .tag_match     (tag_match),
    .cur_index     (cur_index),
    .cur_write     (cur_write)
  );

  cache_dpath #(
    .NUM_LINES      (NUM_LINES),
    .WORDS_PER_LINE (WORDS_PER_LINE)
  ) u_dpath (
    .clk           (clk),
    .reset         (reset),
    .req_addr      (req_addr),
    .req_data      (req_data),
    .req_write     (req_write),
    .mem_resp_data (mem_resp_data),
    .req_capture   (req_capture),
    .tag_rd_en     (tag_rd_en),
    .tag_wr_en     (tag_wr_en),
    .data_rd_en    (data_rd_en),
    .data_wr_en    (data_wr_en),
    .fill_sel      (fill_sel),
    .evict_sel     (evict_sel),
    .req_word_cnt  (req_word_cnt),
    .resp_word_cnt (resp_word_cnt),
    .flush_index   (flush_index),
    .resp_data     (resp_data),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data),
    .tag_match     (tag_match),
    .cur_index     (cur_index),
    .cur_write     (cur_write)
  );

endmodule

// File: logic/cache_dpath.sv
module cache_dpath #(
  parameter int NUM_LINES      = 32,
  parameter int WORDS_PER_LINE = 16,
  localparam int IDX_W = $clog2(NUM_LINES),
  localparam int OFF_W = $clog2(WORDS_PER_LINE),
  localparam int CNT_W = OFF_W + 1,
  localparam int TAG_W = $bits(cache_pkg::addr_t) - IDX_W - OFF_W
) (
  input  logic              clk,
  input  logic              reset,
  input  cache_pkg::addr_t  req_addr,
  input  cache_pkg::word_t  req_data,
  input  logic              req_write,
  input  cache_pkg::word_t  mem_resp_data,
  // controls
  input  logic              req_capture,
  input  logic              tag_rd_en,
  input  logic              tag_wr_en,
  input  logic              data_rd_en,
  input  logic              data_wr_en,
  input  logic              fill_sel,
  input  logic              evict_sel,
  input  logic [CNT_W-1:0]  req_word_cnt,
  input  logic [CNT_W-1:0]  resp_word_cnt,
  input  logic [IDX_W-1:0]  flush_index,
  // results
  output cache_pkg::word_t  resp_data,
  output cache_pkg::addr_t  mem_req_addr,
  output cache_pkg::word_t  mem_req_data,
  output logic              tag_match,
  output logic [IDX_W-1:0]  cur_index,
  output logic              cur_write
);
  import cache_pkg::*;

  logic [TAG_W-1:0]       req_tag_r;
  logic [OFF_W-1:0]       req_off_r;
  word_t                  req_data_r;
  logic                   chk_q;         // high in the tag compare cycle
  logic [TAG_W-1:0]       tag_rd_data;
  logic [IDX_W-1:0]       tag_rd_idx;
  logic [IDX_W+OFF_W-1:0] data_rd_addr;
  logic [IDX_W+OFF_W-1:0] data_wr_addr;
  logic [OFF_W-1:0]       wr_off;
  word_t                  wr_word;
  word_t                  data_rd_data;

  // ====================
  // request registers
  // ====================

  always_ff @(posedge clk) begin
    if (req_capture) begin
      {req_tag_r, cur_index, req_off_r} <= req_addr;  // tag | index | offset
      req_data_r                        <= req_data;
      cur_write                         <= req_write;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      chk_q <= 1'b0;
    end else begin
      chk_q <= req_capture;
    end
  end

  // ====================
  // arrays
  // ====================

  // accepted request reads straight from the port, otherwise the eviction line
  assign tag_rd_idx   = req_capture ? req_addr[OFF_W +: IDX_W] : flush_index;
  assign data_rd_addr = req_capture ? req_addr[IDX_W+OFF_W-1:0]
                                    : {flush_index, req_word_cnt[OFF_W-1:0]};

  assign wr_off       = fill_sel ? resp_word_cnt[OFF_W-1:0] : req_off_r;
  assign data_wr_addr = {cur_index, wr_off};
  // refill word, replaced by the store word at the requested offset
  assign wr_word      = (fill_sel && !(cur_write && wr_off == req_off_r)) ? mem_resp_data
                                                                          : req_data_r;

  cache_sram #(
    .DEPTH (NUM_LINES),
    .WIDTH (TAG_W)
  ) u_tag_array (
    .clk     (clk),
    .rd_en   (tag_rd_en),
    .rd_addr (tag_rd_idx),
    .wr_en   (tag_wr_en),
    .wr_addr (cur_index),
    .wr_data (req_tag_r),
    .rd_data (tag_rd_data)
  );

  cache_sram #(
    .DEPTH (NUM_LINES * WORDS_PER_LINE),
    .WIDTH ($bits(word_t))
  ) u_data_array (
    .clk     (clk),
    .rd_en   (data_rd_en),
    .rd_addr (data_rd_addr),
    .wr_en   (data_wr_en),
    .wr_addr (data_wr_addr),
    .wr_data (wr_word),
    .rd_data (data_rd_data)
  );

  assign tag_match = (tag_rd_data == req_tag_r);  // valid bit applied in the controller

  // ====================
  // memory side
  // ====================

  assign mem_req_addr = evict_sel ? {tag_rd_data, flush_index, req_word_cnt[OFF_W-1:0]}
                                  : {req_tag_r, cur_index, req_word_cnt[OFF_W-1:0]};
  assign mem_req_data = data_rd_data;  // victim word read the cycle before

  // response word, read hit or any write landing on the requested word
  always_ff @(posedge clk) begin
    if (chk_q && !cur_write) begin
      resp_data <= data_rd_data;  // a miss overwrites it during refill
    end else if (data_wr_en && wr_off == req_off_r) begin
      resp_data <= wr_word;
    end
  end

  // store word goes in only right after capture, while the request index is fresh
  a_store_in_compare: assert property (@(posedge clk) disable iff (reset)
    data_wr_en && !fill_sel |-> chk_q && cur_write)
    else $error("store write outside the compare cycle of a write request");

endmodule

// File: logic/cache_ctrl.sv
module cache_ctrl #(
  parameter int NUM_LINES      = 32,
  parameter int WORDS_PER_LINE = 16,
  localparam int IDX_W = $clog2(NUM_LINES),
  localparam int CNT_W = $clog2(WORDS_PER_LINE) + 1
) (
  input  logic             clk,
  input  logic             reset,
  // processor side
  input  logic             req_val,
  output logic             req_rdy,
  output logic             resp_val,
  input  logic             resp_rdy,
  // memory side
  output logic             mem_req_val,
  input  logic             mem_req_rdy,
  output logic             mem_req_write,
  input  logic             mem_resp_val,
  output logic             mem_resp_rdy,
  input  logic             flush,
  output logic             flush_done,
  // datapath controls
  output logic             req_capture,
  output logic             tag_rd_en,
  output logic             tag_wr_en,
  output logic             data_rd_en,
  output logic             data_wr_en,
  output logic             fill_sel,       // 1: memory word, merged with a pending write
  output logic             evict_sel,      // 1: memory address from the stored tag
  output logic [CNT_W-1:0] req_word_cnt,   // words requested or sent
  output logic [CNT_W-1:0] resp_word_cnt,  // words received on refill
  output logic [IDX_W-1:0] flush_index,    // line being evicted, walk position in a flush
  // datapath status
  input  logic             tag_match,
  input  logic [IDX_W-1:0] cur_index,
  input  logic             cur_write
);
  import cache_pkg::*;

  localparam logic [CNT_W-1:0] LINE_WORDS = CNT_W'(WORDS_PER_LINE);
  localparam logic [IDX_W-1:0] LAST_LINE  = IDX_W'(NUM_LINES - 1);

  ctrl_state_t          state;
  ctrl_state_t          next_state;
  logic [NUM_LINES-1:0] valid_bits;
  logic [NUM_LINES-1:0] dirty_bits;
  logic                 flushing;    // current eviction belongs to a flush
  logic                 ev_data_ok;  // victim word sitting on the data array output
  logic                 hit;
  logic                 ev_rd;
  logic                 req_fire;
  logic                 walk_clean;  // walk position needs no write-back

  assign hit        = valid_bits[cur_index] && tag_match;
  assign ev_rd      = !ev_data_ok && (req_word_cnt < LINE_WORDS);
  assign walk_clean = !dirty_bits[flush_index];

  // ====================
  // handshake outputs
  // ====================

  assign req_rdy       = (state == idle) && !flush;  // blocked during a flush
  assign req_capture   = req_val && req_rdy;
  assign resp_val      = (state == respond);
  assign mem_req_write = (state == evict);
  assign mem_resp_rdy  = (state == refill);         // always take refill data
  assign mem_req_val   = (state == evict) ? ev_data_ok
                                          : (state == refill) && (req_word_cnt < LINE_WORDS);
  assign req_fire      = mem_req_val && mem_req_rdy;

  // ====================
  // control table
  // ====================

  task automatic cs(
    input logic cs_tag_rd,
    input logic cs_tag_wr,
    input logic cs_data_rd,
    input logic cs_data_wr,
    input logic cs_fill,
    input logic cs_evict
  );
    tag_rd_en  = cs_tag_rd;
    tag_wr_en  = cs_tag_wr;
    data_rd_en = cs_data_rd;
    data_wr_en = cs_data_wr;
    fill_sel   = cs_fill;
    evict_sel  = cs_evict;
  endtask

  always_comb begin
    case (state)
      //              tag_rd       tag_wr  data_rd      data_wr              fill  evict
      idle:       cs(req_capture, 1'b0,   req_capture, 1'b0,                1'b0, 1'b0);
      tag_check:  cs(1'b0,        1'b0,   1'b0,        hit && cur_write,    1'b0, 1'b0);
      evict:      cs(1'b0,        1'b0,   ev_rd,       1'b0,                1'b0, 1'b1);
      refill:     cs(1'b0,        1'b1,   1'b0,        mem_resp_val,        1'b1, 1'b0);
      flush_walk: cs(1'b1,        1'b0,   1'b0,        1'b0,                1'b0, 1'b1);
      default:    cs(1'b0,        1'b0,   1'b0,        1'b0,                1'b0, 1'b0);
    endcase
  end

  // ====================
  // next state
  // ====================

  always_comb begin
    next_state = state;
    case (state)
      idle: begin
        if (flush && !flush_done) begin
          next_state = flush_walk;
        end else if (req_capture) begin
          next_state = tag_check;
        end
      end
      tag_check: begin
        if (hit) begin
          next_state = respond;
        end else if (dirty_bits[cur_index]) begin
          next_state = evict;  // victim must go out first
        end else begin
          next_state = refill;
        end
      end
      evict: begin
        if (req_word_cnt == LINE_WORDS) begin
          next_state = flushing ? flush_walk : refill;
        end
      end
      refill: begin
        if (req_word_cnt == LINE_WORDS && resp_word_cnt == LINE_WORDS) begin
          next_state = respond;
        end
      end
      respond: begin
        if (resp_rdy) begin
          next_state = idle;
        end
      end
      flush_walk: begin
        if (!walk_clean) begin
          next_state = evict;
        end else if (flush_index == LAST_LINE) begin
          next_state = idle;
        end
      end
      default: next_state = idle;
    endcase
  end

  // ====================
  // state and counters
  // ====================

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= idle;
      req_word_cnt  <= '0;
      resp_word_cnt <= '0;
      ev_data_ok    <= 1'b0;
    end else begin
      state <= next_state;
      if (state != next_state) begin  // every state entry starts a fresh count
        req_word_cnt  <= '0;
        resp_word_cnt <= '0;
      end else begin
        if (req_fire) begin
          req_word_cnt <= req_word_cnt + 1'b1;
        end
        if (mem_resp_val && mem_resp_rdy) begin
          resp_word_cnt <= resp_word_cnt + 1'b1;
        end
      end
      if (state != evict || req_fire) begin
        ev_data_ok <= 1'b0;  // word consumed, read the next one
      end else if (data_rd_en) begin
        ev_data_ok <= 1'b1;
      end
    end
  end

  // walk position, flush status
  always_ff @(posedge clk) begin
    if (reset) begin
      flush_index <= '0;
      flushing    <= 1'b0;
      flush_done  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (next_state == flush_walk) begin
            flush_index <= '0;
            flushing    <= 1'b1;
          end
        end
        tag_check: flush_index <= cur_index;  // miss eviction uses the request line
        flush_walk: begin
          if (walk_clean && flush_index != LAST_LINE) begin
            flush_index <= flush_index + 1'b1;
          end else if (walk_clean) begin
            flushing <= 1'b0;
          end
        end
        default: ;
      endcase
      if (!flush) begin
        flush_done <= 1'b0;
      end else if (state == flush_walk && next_state == idle) begin
        flush_done <= 1'b1;  // held until flush drops
      end
    end
  end

  // line status bits
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (state == tag_check && hit && cur_write) begin
        dirty_bits[cur_index] <= 1'b1;
      end
      if (state == evict && next_state != evict) begin
        dirty_bits[flush_index] <= 1'b0;  // line now matches memory
      end
      if (state == refill && next_state == respond) begin
        valid_bits[cur_index] <= 1'b1;
        dirty_bits[cur_index] <= cur_write;  // write miss merged during refill
      end
    end
  end

  // ====================
  // checks
  // ====================

  a_state_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(state))
    else $error("controller state unknown");

  a_mem_req_hold: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val)
    else $error("memory request dropped before acceptance");

  a_cnt_bound: assert property (@(posedge clk) disable iff (reset)
    req_word_cnt <= LINE_WORDS && resp_word_cnt <= LINE_WORDS)
    else $error("word counter past line size");

endmodule

// File: logic/cache_sram.sv
module cache_sram #(
  parameter int DEPTH = 32,
  parameter int WIDTH = 32,
  localparam int AW = $clog2(DEPTH)
) (
  input  logic             clk,
  input  logic             rd_en,
  input  logic [AW-1:0]    rd_addr,
  input  logic             wr_en,
  input  logic [AW-1:0]    wr_addr,
  input  logic [WIDTH-1:0] wr_data,
  output logic [WIDTH-1:0] rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];  // storage, contents undefined until written

  // one write port, one registered read port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    if (rd_en) begin
      rd_data <= mem[rd_addr];  // same-address write lands after, old word out
    end
  end

endmodule

// File: logic/cache_pkg.sv
package cache_pkg;

  // ====================
  // data and address
  // ====================

  typedef logic [31:0] word_t;  // one cache or memory word
  typedef logic [31:0] addr_t;  // word address, no byte offset bits

  // ====================
  // controller states
  // ====================

  typedef enum logic [2:0] {
    idle,        // waiting for a request or a flush
    tag_check,   // arrays read last cycle, compare now
    evict,       // write the dirty victim line back
    refill,      // fetch the missing line, merge a write word
    respond,     // hold the response until it is taken
    flush_walk   // step over every line looking for dirty ones
  } ctrl_state_t;

endpackage
